/* all.f */
tmu_pkg.sv
tmu_cfg_if.sv
tmu_ctlif.sv
tmu_square_walker.sv
tmu_dst_addr.sv
tmu_top.sv
tb_tmu_assert.sv
tb_tmu.sv

/* run.sh */
#!/bin/bash
# Compiles the TMU testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu -f all.f \
	-o sim_tmu > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_tmu +verilator+error+limit+100 > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No pass result in sim.log"; exit 1; }
echo "Simulation passed"

/* tb_tmu.sv */
// Testbench for the texture-mapping-unit front end.
// Drives the CSR bus, checks register readback inline and runs several
// walks. The bound checker compares the pixel stream and the interrupt.

`timescale 1ns/1ps

module tb_tmu;
	import tmu_pkg::*;

	localparam int FML_DEPTH = 26;
	localparam logic [3:0] BANK = 4'h0;
	localparam logic [31:0] FBUF_MASK = ((32'd1 << FML_DEPTH) - 32'd1) & ~32'd1;
	// Register tests take about 150 cycles, each walk well under 300.
	localparam int TIMEOUT_CYCLES = 20000;

	logic sys_clk;
	logic sys_rst;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic irq;
	logic pix_valid;
	logic pix_ready = 1'b1;
	logic [FML_DEPTH-2:0] pix_adr;

	logic [31:0] data_lfsr = 32'h31be;
	logic [31:0] ready_lfsr = 32'h31be;
	logic rand_ready = 1'b0;
	int cycle_cnt = 0;
	int irq_cnt = 0;
	int walks = 0;
	logic [31:0] wdata;

	tmu_top #(.csr_addr(BANK), .fml_depth(FML_DEPTH)) UUT (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.csr_a     (csr_a),
		.csr_we    (csr_we),
		.csr_di    (csr_di),
		.csr_do    (csr_do),
		.irq       (irq),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix_adr   (pix_adr)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Fibonacci LFSR, taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] expected_readback(input logic [4:0] idx,
			input logic [31:0] w);
		case (idx)
			REG_VLAST_H, REG_VLAST_V:   return {25'd0, w[6:0]};
			REG_DST_FBUF:               return w & FBUF_MASK;
			REG_DST_HOFF, REG_DST_VOFF: return {{20{w[11]}}, w[11:0]};
			default:                    return {21'd0, w[10:0]};
		endcase
	endfunction

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			data_lfsr = lfsr_next(data_lfsr);
			w = {w[30:0], data_lfsr[0]};
		end
	endtask

	task automatic csr_write(input logic [4:0] idx, input logic [31:0] data);
		@(posedge sys_clk);
		csr_a <= {BANK, 5'd0, idx};
		csr_di <= data;
		csr_we <= 1'b1;
		@(posedge sys_clk);
		csr_we <= 1'b0;
	endtask

	// Read data is registered, so it is sampled a full cycle later.
	task automatic check_read(input logic [4:0] idx, input logic [3:0] bank,
			input logic [31:0] expected, input string name);
		@(posedge sys_clk);
		csr_a <= {bank, 5'd0, idx};
		csr_we <= 1'b0;
		@(posedge sys_clk);
		@(negedge sys_clk);
		if (csr_do !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, csr_do);
			stop_on_failure();
		end
	endtask

	task automatic setup_walk(input logic [31:0] hlast, input logic [31:0] vlast,
			input logic [31:0] sqw, input logic [31:0] sqh, input logic [31:0] hres,
			input logic [31:0] vres, input logic [31:0] hoff, input logic [31:0] voff,
			input logic [31:0] fbuf);
		csr_write(REG_VLAST_H, hlast);
		csr_write(REG_VLAST_V, vlast);
		csr_write(REG_SQ_W, sqw);
		csr_write(REG_SQ_H, sqh);
		csr_write(REG_DST_HRES, hres);
		csr_write(REG_DST_VRES, vres);
		csr_write(REG_DST_HOFF, hoff);
		csr_write(REG_DST_VOFF, voff);
		csr_write(REG_DST_FBUF, fbuf);
	endtask

	task automatic run_walk(input string name);
		walks++;
		csr_write(REG_CTRL, 32'd1);
		do @(negedge sys_clk); while (irq_cnt < walks);
		repeat (4) @(negedge sys_clk); // Room for a second, wrong pulse.
		if (irq_cnt != walks) begin
			$display("CHECK FAILED %s irq count: expected %0d, actual %0d", name, walks, irq_cnt);
			stop_on_failure();
		end
		check_read(REG_CTRL, BANK, 32'd0, {name, " busy"});
	endtask

	// ************************************************************************
	// Random ready, cycle limit, irq counter, checker flag
	// ************************************************************************

	always @(posedge sys_clk) begin
		if (rand_ready) begin
			ready_lfsr = lfsr_next(ready_lfsr);
			pix_ready <= ready_lfsr[0];
		end else begin
			pix_ready <= 1'b1;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!sys_rst && irq)
			irq_cnt <= irq_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_on_failure();
		end
		if (UUT.checks.any_fail) begin
			$display("A bound assertion on the pixel stream or the interrupt failed");
			stop_on_failure();
		end
	end

	// ************************************************************************
	// Test sequence
	// ************************************************************************

	initial begin
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		repeat (16) @(posedge sys_clk);
		sys_rst <= 1'b0;

		check_read(REG_CTRL, BANK, 32'd0, "reset ctrl");
		check_read(REG_VLAST_H, BANK, 32'd32, "reset vertex_hlast");
		check_read(REG_VLAST_V, BANK, 32'd24, "reset vertex_vlast");
		check_read(REG_DST_FBUF, BANK, 32'd0, "reset dst_fbuf");
		check_read(REG_DST_HRES, BANK, 32'd640, "reset dst_hres");
		check_read(REG_DST_VRES, BANK, 32'd480, "reset dst_vres");
		check_read(REG_DST_HOFF, BANK, 32'd0, "reset dst_hoffset");
		check_read(REG_DST_VOFF, BANK, 32'd0, "reset dst_voffset");
		check_read(REG_SQ_W, BANK, 32'd20, "reset dst_squarew");
		check_read(REG_SQ_H, BANK, 32'd20, "reset dst_squareh");
		check_read(5'd10, BANK, 32'd0, "unmapped index");
		check_read(REG_DST_HRES, 4'h1, 32'd0, "other bank");

		for (int i = 1; i <= 9; i++) begin
			random_word(wdata);
			csr_write(5'(i), wdata);
			check_read(5'(i), BANK, expected_readback(5'(i), wdata),
				$sformatf("readback of register %0d", i));
		end

		setup_walk(3, 2, 8, 8, 32, 16, 0, 0, 32'h1000);
		run_walk("grid 4x3");

		// First column left of the screen, last row below it.
		setup_walk(3, 2, 12, 9, 32, 16, -32'sd10, 2, 32'h2468);
		run_walk("clipped walk");

		rand_ready <= 1'b1;
		setup_walk(5, 3, 5, 5, 24, 15, 1, 1, 32'h2000);
		run_walk("random ready");
		run_walk("second start");
		rand_ready <= 1'b0;

		if (UUT.checks.any_fail) begin
			stop_on_failure();
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

/* tb_tmu_assert.sv */
// Checker bound to the TMU top level.
// Mirrors CSR writes, replays the vertex walk with the clipping rules on
// each start and compares the pixel stream and the interrupt with it.

`timescale 1ns/1ps

module tb_tmu_assert #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int fml_depth = 26
) (
	input logic                 sys_clk,
	input logic                 sys_rst,
	input logic [13:0]          csr_a,
	input logic                 csr_we,
	input logic [31:0]          csr_di,
	input logic                 irq,
	input logic                 pix_valid,
	input logic                 pix_ready,
	input logic [fml_depth-2:0] pix_adr
);
	import tmu_pkg::*;

	logic [VTX_W-1:0] m_hlast;
	logic [VTX_W-1:0] m_vlast;
	logic [fml_depth-2:0] m_fbuf;
	logic [RES_W-1:0] m_hres;
	logic [RES_W-1:0] m_vres;
	logic [RES_W-1:0] m_sqw;
	logic [RES_W-1:0] m_sqh;
	logic signed [OFF_W-1:0] m_hoff;
	logic signed [OFF_W-1:0] m_voff;

	logic [fml_depth-2:0] exp_q[$];   // Addresses still to come.
	logic [fml_depth-2:0] exp_head;
	int exp_count;
	logic walk_open;

	logic bad_order = 1'b0;
	logic bad_hold = 1'b0;
	logic bad_irq = 1'b0;
	logic bad_pulse = 1'b0;
	logic any_fail;

	assign any_fail = bad_order | bad_hold | bad_irq | bad_pulse;

	// Row by row, vx fastest, points outside the resolution dropped.
	task automatic queue_walk();
		longint x;
		longint y;
		longint adr;
		exp_q.delete();
		for (int vy = 0; vy <= int'(m_vlast); vy++) begin
			for (int vx = 0; vx <= int'(m_hlast); vx++) begin
				x = longint'(m_hoff) + longint'(vx) * longint'(m_sqw);
				y = longint'(m_voff) + longint'(vy) * longint'(m_sqh);
				if (x >= 0 && x < longint'(m_hres) && y >= 0 && y < longint'(m_vres)) begin
					adr = longint'(m_fbuf) + y * longint'(m_hres) + x;
					exp_q.push_back(adr[fml_depth-2:0]); // Wraps with the address width.
				end
			end
		end
	endtask

	// ************************************************************************
	// CSR mirror and expected stream
	// ************************************************************************

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			m_hlast <= VTX_W'(32);
			m_vlast <= VTX_W'(24);
			m_fbuf <= '0;
			m_hres <= RES_W'(640);
			m_vres <= RES_W'(480);
			m_hoff <= '0;
			m_voff <= '0;
			m_sqw <= RES_W'(20);
			m_sqh <= RES_W'(20);
			exp_q.delete();
			walk_open <= 1'b0;
		end else begin
			if (pix_valid && pix_ready && exp_q.size() > 0)
				void'(exp_q.pop_front());
			if (csr_we && (csr_a[13:10] == csr_addr)) begin
				case (csr_a[4:0])
					REG_CTRL: begin
						if (csr_di[0] && !walk_open) begin
							queue_walk();
							walk_open <= 1'b1;
						end
					end
					REG_VLAST_H:  m_hlast <= csr_di[VTX_W-1:0];
					REG_VLAST_V:  m_vlast <= csr_di[VTX_W-1:0];
					REG_DST_FBUF: m_fbuf <= csr_di[fml_depth-1:1];
					REG_DST_HRES: m_hres <= csr_di[RES_W-1:0];
					REG_DST_VRES: m_vres <= csr_di[RES_W-1:0];
					REG_DST_HOFF: m_hoff <= csr_di[OFF_W-1:0];
					REG_DST_VOFF: m_voff <= csr_di[OFF_W-1:0];
					REG_SQ_W:     m_sqw <= csr_di[RES_W-1:0];
					REG_SQ_H:     m_sqh <= csr_di[RES_W-1:0];
					default:      ;
				endcase
			end
			if (irq)
				walk_open <= 1'b0; // Walk finished.
		end
		exp_count <= exp_q.size();
		exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
	end

	// ************************************************************************
	// Stream and interrupt properties
	// ************************************************************************

	a_pix_order: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(pix_valid && pix_ready) |-> (exp_count > 0 && pix_adr == exp_head))
	else begin
		bad_order = 1'b1;
		$error("pixel address missing, extra or out of order");
	end

	a_pix_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_adr)))
	else begin
		bad_hold = 1'b1;
		$error("stalled pixel address changed or was dropped");
	end

	a_irq_done: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |-> (walk_open && exp_count == 0))
	else begin
		bad_irq = 1'b1;
		$error("interrupt without a finished walk");
	end

	a_irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |=> !irq)
	else begin
		bad_pulse = 1'b1;
		$error("interrupt longer than one cycle");
	end

endmodule

bind tmu_top tb_tmu_assert #(
	.csr_addr  (csr_addr),
	.fml_depth (fml_depth)
) checks (
	.sys_clk   (sys_clk),
	.sys_rst   (sys_rst),
	.csr_a     (csr_a),
	.csr_we    (csr_we),
	.csr_di    (csr_di),
	.irq       (irq),
	.pix_valid (pix_valid),
	.pix_ready (pix_ready),
	.pix_adr   (pix_adr)
);

/* tmu_top.sv */
// Top level of the texture-mapping-unit front end.
// The CSR block configures the square walker through the configuration
// interface; walked points pass through the address pipeline and leave as
// a valid/ready stream of framebuffer word addresses.

`timescale 1ns/1ps

module tmu_top #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  logic [13:0]          csr_a,
	input  logic                 csr_we,
	input  logic [31:0]          csr_di,
	output logic [31:0]          csr_do,
	output logic                 irq,

	output logic                 pix_valid,
	input  logic                 pix_ready,
	output logic [fml_depth-2:0] pix_adr
);
	import tmu_pkg::*;

	logic pt_valid;
	logic pt_ready;
	logic [RES_W-1:0] pt_x;
	logic [RES_W-1:0] pt_y;
	logic pipe_empty;

	tmu_cfg_if #(.fml_depth(fml_depth)) cfg ();

	tmu_ctlif #(
		.csr_addr  (csr_addr),
		.fml_depth (fml_depth)
	) ctlif (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.irq     (irq),
		.cfg     (cfg.ctl)
	);

	tmu_square_walker walker (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.cfg        (cfg.eng),
		.pt_valid   (pt_valid),
		.pt_ready   (pt_ready),
		.pt_x       (pt_x),
		.pt_y       (pt_y),
		.pipe_empty (pipe_empty)
	);

	tmu_dst_addr #(
		.fml_depth (fml_depth)
	) dst_addr (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pt_valid   (pt_valid),
		.pt_ready   (pt_ready),
		.pt_x       (pt_x),
		.pt_y       (pt_y),
		.dst_fbuf   (cfg.dst_fbuf), // Base address straight from the CSR bank.
		.dst_hres   (cfg.dst_hres),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.pix_adr    (pix_adr),
		.pipe_empty (pipe_empty)
	);

endmodule

/* tmu_dst_addr.sv */
// Destination address pipeline of the texture-mapping-unit front end.
// Turns a screen point into a 16-bit-pixel framebuffer word address in two
// stages: y * hres + x, then the framebuffer base. One enable freezes both
// stages while the output is stalled.

`timescale 1ns/1ps

module tmu_dst_addr #(
	parameter int fml_depth = 26
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst,

	input  logic                      pt_valid,
	output logic                      pt_ready,
	input  logic [tmu_pkg::RES_W-1:0] pt_x,
	input  logic [tmu_pkg::RES_W-1:0] pt_y,

	input  logic [fml_depth-2:0]      dst_fbuf,
	input  logic [tmu_pkg::RES_W-1:0] dst_hres,

	output logic                      pix_valid,
	input  logic                      pix_ready,
	output logic [fml_depth-2:0]      pix_adr,

	output logic                      pipe_empty
);
	import tmu_pkg::*;

	localparam int AW = fml_depth - 1;

	logic en;
	logic [2*RES_W:0] row_full;   // Full y * hres + x.

	logic s1_valid;
	logic [AW-1:0] s1_row;
	logic s2_valid;
	logic [AW-1:0] s2_adr;

	assign en = ~(s2_valid & ~pix_ready); // Stall on back-pressure.
	assign pt_ready = en;
	assign row_full = pt_y * dst_hres + pt_x;

	assign pix_valid = s2_valid;
	assign pix_adr = s2_adr;
	assign pipe_empty = ~s1_valid & ~s2_valid;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (en) begin
			s1_valid <= pt_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (en) begin
			s1_row <= AW'(row_full);      // Modulo the address space.
			s2_adr <= s1_row + dst_fbuf;
		end
	end

endmodule

/* tmu_square_walker.sv */
// Vertex grid walker of the texture-mapping-unit front end.
// After a start pulse it visits every vertex row by row, forms the screen
// point offset + index * square size by running sums, drops points outside
// the destination resolution and offers the rest on a valid/ready stream.
// Busy stays high until the address pipeline behind it has drained.

`timescale 1ns/1ps

module tmu_square_walker (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	tmu_cfg_if.eng                   cfg,

	output logic                     pt_valid,
	input  logic                     pt_ready,
	output logic [tmu_pkg::RES_W-1:0] pt_x,
	output logic [tmu_pkg::RES_W-1:0] pt_y,

	input  logic                     pipe_empty
);
	import tmu_pkg::*;

	// Wide enough for 127 squares of 2047 pixels plus a signed offset.
	localparam int PW = RES_W + VTX_W + 2;

	walk_state_e state;

	logic [VTX_W-1:0] vx;
	logic [VTX_W-1:0] vy;
	logic signed [PW-1:0] x_acc;           // Screen x of the current vertex.
	logic signed [PW-1:0] y_acc;

	logic signed [PW-1:0] hoff_ext;
	logic signed [PW-1:0] voff_ext;
	logic signed [PW-1:0] sqw_ext;
	logic signed [PW-1:0] sqh_ext;
	logic signed [PW-1:0] hres_ext;
	logic signed [PW-1:0] vres_ext;

	logic can_issue;
	logic in_range;
	logic row_end;
	logic last_vtx;

	assign hoff_ext = PW'(cfg.dst_hoffset); // Sign-extended.
	assign voff_ext = PW'(cfg.dst_voffset);
	assign sqw_ext  = {{(PW-RES_W){1'b0}}, cfg.dst_squarew};
	assign sqh_ext  = {{(PW-RES_W){1'b0}}, cfg.dst_squareh};
	assign hres_ext = {{(PW-RES_W){1'b0}}, cfg.dst_hres};
	assign vres_ext = {{(PW-RES_W){1'b0}}, cfg.dst_vres};

	assign can_issue = ~pt_valid | pt_ready; // Output slot free next edge.
	assign in_range = ~x_acc[PW-1] && (x_acc < hres_ext)
		&& ~y_acc[PW-1] && (y_acc < vres_ext);
	assign row_end  = (vx == cfg.vertex_hlast);
	assign last_vtx = row_end && (vy == cfg.vertex_vlast);

	assign cfg.busy = (state != IDLE);

	// ************************************************************************
	// Walk control
	// ************************************************************************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			pt_valid <= 1'b0;
		end else begin
			if (pt_ready)
				pt_valid <= 1'b0; // Point taken downstream.
			case (state)
				IDLE: begin
					if (cfg.start)
						state <= WALK;
				end
				WALK: begin
					if (can_issue) begin
						if (in_range)
							pt_valid <= 1'b1;
						if (last_vtx)
							state <= DRAIN;
					end
				end
				DRAIN: begin
					if (~pt_valid && pipe_empty)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ************************************************************************
	// Vertex counters, running sums and point register
	// ************************************************************************

	always_ff @(posedge sys_clk) begin
		if ((state == IDLE) && cfg.start) begin
			vx <= '0;
			vy <= '0;
			x_acc <= hoff_ext;
			y_acc <= voff_ext;
		end else if ((state == WALK) && can_issue) begin
			if (in_range) begin
				pt_x <= x_acc[RES_W-1:0];
				pt_y <= y_acc[RES_W-1:0];
			end
			if (row_end) begin
				vx <= '0;
				x_acc <= hoff_ext;         // Back to the left edge.
				vy <= vy + 1'b1;
				y_acc <= y_acc + sqh_ext;
			end else begin
				vx <= vx + 1'b1;
				x_acc <= x_acc + sqw_ext;
			end
		end
	end

endmodule

/* tmu_ctlif.sv */
// CSR register bank of the texture-mapping-unit front end.
// Decodes the bank number in csr_a[13:10], writes the geometry registers,
// returns registered read data one cycle after the address, emits the
// start pulse and raises irq for one cycle when the engine goes idle.

`timescale 1ns/1ps

module tmu_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int fml_depth = 26
) (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  logic [31:0] csr_di,
	output logic [31:0] csr_do,

	output logic        irq,

	tmu_cfg_if.ctl      cfg
);
	import tmu_pkg::*;

	logic old_busy;
	logic csr_selected;
	tmu_reg_e reg_idx;

	assign csr_selected = (csr_a[13:10] == csr_addr);
	assign reg_idx = tmu_reg_e'(csr_a[4:0]);

	// ************************************************************************
	// Completion interrupt
	// ************************************************************************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			old_busy <= 1'b0;
			irq <= 1'b0;
		end else begin
			old_busy <= cfg.busy;
			irq <= old_busy & ~cfg.busy; // Falling edge of busy.
		end
	end

	// ************************************************************************
	// Register writes and start pulse
	// ************************************************************************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg.start <= 1'b0;
			cfg.vertex_hlast <= VTX_W'(32);
			cfg.vertex_vlast <= VTX_W'(24);
			cfg.dst_fbuf <= '0;
			cfg.dst_hres <= RES_W'(640);
			cfg.dst_vres <= RES_W'(480);
			cfg.dst_hoffset <= '0;
			cfg.dst_voffset <= '0;
			cfg.dst_squarew <= RES_W'(20);
			cfg.dst_squareh <= RES_W'(20);
		end else begin
			cfg.start <= 1'b0; // Pulse lasts a single cycle.
			if (csr_selected && csr_we) begin
				case (reg_idx)
					REG_CTRL:     cfg.start <= csr_di[0];
					REG_VLAST_H:  cfg.vertex_hlast <= csr_di[VTX_W-1:0];
					REG_VLAST_V:  cfg.vertex_vlast <= csr_di[VTX_W-1:0];
					REG_DST_FBUF: cfg.dst_fbuf <= csr_di[fml_depth-1:1];
					REG_DST_HRES: cfg.dst_hres <= csr_di[RES_W-1:0];
					REG_DST_VRES: cfg.dst_vres <= csr_di[RES_W-1:0];
					REG_DST_HOFF: cfg.dst_hoffset <= csr_di[OFF_W-1:0];
					REG_DST_VOFF: cfg.dst_voffset <= csr_di[OFF_W-1:0];
					REG_SQ_W:     cfg.dst_squarew <= csr_di[RES_W-1:0];
					REG_SQ_H:     cfg.dst_squareh <= csr_di[RES_W-1:0];
					default:      ;
				endcase
			end
		end
	end

	// ************************************************************************
	// Registered read data
	// ************************************************************************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= 32'd0;
		end else begin
			csr_do <= 32'd0; // Unselected bank or unmapped index.
			if (csr_selected) begin
				case (reg_idx)
					REG_CTRL:     csr_do <= {31'd0, cfg.busy};
					REG_VLAST_H:  csr_do <= 32'(cfg.vertex_hlast);
					REG_VLAST_V:  csr_do <= 32'(cfg.vertex_vlast);
					REG_DST_FBUF: csr_do <= 32'({cfg.dst_fbuf, 1'b0});
					REG_DST_HRES: csr_do <= 32'(cfg.dst_hres);
					REG_DST_VRES: csr_do <= 32'(cfg.dst_vres);
					REG_DST_HOFF: csr_do <= 32'(cfg.dst_hoffset); // Sign-extended.
					REG_DST_VOFF: csr_do <= 32'(cfg.dst_voffset);
					REG_SQ_W:     csr_do <= 32'(cfg.dst_squarew);
					REG_SQ_H:     csr_do <= 32'(cfg.dst_squareh);
					default:      csr_do <= 32'd0;
				endcase
			end
		end
	end

endmodule

/* tmu_cfg_if.sv */
// Configuration bundle from the CSR block to the rendering engine.
// The control side drives the registers and the start pulse, the engine
// side returns busy. Registers only change while busy is low.

`timescale 1ns/1ps

interface tmu_cfg_if #(
	parameter int fml_depth = 26
);
	import tmu_pkg::*;

	logic start;                       // One-cycle launch pulse.
	logic busy;

	logic [VTX_W-1:0] vertex_hlast;    // Last vertex column, inclusive.
	logic [VTX_W-1:0] vertex_vlast;    // Last vertex row, inclusive.

	logic [fml_depth-2:0] dst_fbuf;    // Framebuffer base in 16-bit words.
	logic [RES_W-1:0] dst_hres;
	logic [RES_W-1:0] dst_vres;
	logic signed [OFF_W-1:0] dst_hoffset;
	logic signed [OFF_W-1:0] dst_voffset;
	logic [RES_W-1:0] dst_squarew;
	logic [RES_W-1:0] dst_squareh;

	modport ctl (
		output start, vertex_hlast, vertex_vlast,
		output dst_fbuf, dst_hres, dst_vres,
		output dst_hoffset, dst_voffset, dst_squarew, dst_squareh,
		input busy
	);

	modport eng (
		input start, vertex_hlast, vertex_vlast,
		input dst_fbuf, dst_hres, dst_vres,
		input dst_hoffset, dst_voffset, dst_squarew, dst_squareh,
		output busy
	);

endinterface

/* tmu_pkg.sv */
// Shared definitions for the texture-mapping-unit front end.
// Holds the CSR register index map, the walker state encoding and the
// widths of the geometry fields. Imported by the interface and the RTL.

package tmu_pkg;

	// ************************************************************************
	// Field widths
	// ************************************************************************

	localparam int RES_W = 11; // Resolutions, square sizes, coordinates.
	localparam int OFF_W = 12; // Signed screen offsets.
	localparam int VTX_W = 7;  // Vertex grid indices.

	// ************************************************************************
	// CSR register index, taken from csr_a[4:0]
	// ************************************************************************

	typedef enum logic [4:0] {
		REG_CTRL     = 5'd0,  // Bit 0 starts a walk, reads back busy.
		REG_VLAST_H  = 5'd1,
		REG_VLAST_V  = 5'd2,
		REG_DST_FBUF = 5'd3,  // Byte address, bit 0 always zero.
		REG_DST_HRES = 5'd4,
		REG_DST_VRES = 5'd5,
		REG_DST_HOFF = 5'd6,
		REG_DST_VOFF = 5'd7,
		REG_SQ_W     = 5'd8,
		REG_SQ_H     = 5'd9
	} tmu_reg_e;

	// Square walker FSM.
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		WALK  = 2'd1, // Stepping over the vertex grid.
		DRAIN = 2'd2  // Waiting for the address pipeline to empty.
	} walk_state_e;

endpackage
